// ==== prc_defs.svh ====
`ifndef PRC_DEFS_SVH
`define PRC_DEFS_SVH

// CPU visible registers
`define PRC_REG_MODE      24'h002080
`define PRC_REG_RATE      24'h002081
`define PRC_REG_MAP_LO    24'h002082
`define PRC_REG_MAP_MID   24'h002083
`define PRC_REG_MAP_HI    24'h002084
`define PRC_REG_SCROLL_Y  24'h002085
`define PRC_REG_SCROLL_X  24'h002086
`define PRC_REG_COUNTER   24'h00208A

// Memory map seen by the engines
`define PRC_FB_BASE       24'h001000
`define PRC_TILEMAP_BASE  24'h001360
`define PRC_LCD_CMD       24'h0020FE
`define PRC_LCD_DATA      24'h0020FF

// Framebuffer and map geometry
`define PRC_FB_COLUMNS    96
`define PRC_FB_PAGES      8
`define PRC_MAP_COLUMNS   12

// Frame timing
`define PRC_TICK_CLOCKS   855
`define PRC_RENDER_TICK   7'h18
`define PRC_FRAME_TICKS   7'h42

`endif

// ==== prc_pkg.sv ====
`default_nettype none

package prc_pkg;

    // One engine bus access
    typedef struct packed
    {
        logic [23:0] address;
        logic [7:0]  data;
        logic        read;
        logic        write;
    } prc_bus_cmd_t;

    // CPU visible register state
    typedef struct packed
    {
        logic [5:0]  mode;      // Bit 1 map draw, bit 3 frame copy
        logic [7:0]  rate;      // 7:4 skipped frames, 3:1 divider
        logic [23:0] map_base;
        logic [6:0]  scroll_x;
        logic [6:0]  scroll_y;
    } prc_regs_t;

    typedef enum logic [1:0]
    {
        ENGINE_IDLE,
        ENGINE_MAP_DRAW,
        ENGINE_FRAME_COPY
    } prc_engine_e;

endpackage

`default_nettype wire

// ==== prc_registers.sv ====
`default_nettype none

`include "prc_defs.svh"

module prc_registers import prc_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        bus_write,
    input  wire logic [23:0] bus_address_in,
    input  wire logic [7:0]  bus_data_in,
    input  wire logic        skip_clear,
    input  wire logic        skip_increment,
    input  wire logic [6:0]  counter,
    output prc_regs_t        regs,
    output logic      [7:0]  read_data,
    output logic             divider_changed
);

    // A new divider setting restarts the skip count
    assign divider_changed = bus_write && bus_address_in == `PRC_REG_RATE
                             && regs.rate[3:1] != bus_data_in[3:1];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            regs <= '0;
        end
        else
        begin
            if (skip_clear)
                regs.rate[7:4] <= 4'd0;
            else if (skip_increment)
                regs.rate[7:4] <= regs.rate[7:4] + 4'd1;

            if (bus_write)
            begin
                case (bus_address_in)
                    `PRC_REG_MODE:     regs.mode <= bus_data_in[5:0];
                    `PRC_REG_RATE:
                    begin
                        regs.rate[3:0] <= bus_data_in[3:0];
                        if (divider_changed)
                            regs.rate[7:4] <= 4'd0;
                    end
                    `PRC_REG_MAP_LO:   regs.map_base[7:3]   <= bus_data_in[7:3];
                    `PRC_REG_MAP_MID:  regs.map_base[15:8]  <= bus_data_in;
                    `PRC_REG_MAP_HI:   regs.map_base[20:16] <= bus_data_in[4:0];
                    `PRC_REG_SCROLL_Y: regs.scroll_y <= bus_data_in[6:0];
                    `PRC_REG_SCROLL_X: regs.scroll_x <= bus_data_in[6:0];
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    always_comb
    begin
        case (bus_address_in)
            `PRC_REG_MODE:     read_data = {2'd0, regs.mode};
            `PRC_REG_RATE:     read_data = regs.rate;
            `PRC_REG_MAP_LO:   read_data = regs.map_base[7:0];
            `PRC_REG_MAP_MID:  read_data = regs.map_base[15:8];
            `PRC_REG_MAP_HI:   read_data = regs.map_base[23:16];
            `PRC_REG_SCROLL_Y: read_data = {1'b0, regs.scroll_y};
            `PRC_REG_SCROLL_X: read_data = {1'b0, regs.scroll_x};
            `PRC_REG_COUNTER:  read_data = {1'b0, counter};
            default:           read_data = 8'd0; // Sprite bases included
        endcase
    end

endmodule

`default_nettype wire

// ==== prc_frame_timer.sv ====
`default_nettype none

`include "prc_defs.svh"

module prc_frame_timer import prc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  prc_regs_t  regs,
    output logic [6:0] counter,
    output logic       skip_clear,
    output logic       skip_increment,
    output logic       bus_request,
    output logic       render_start,
    output logic       irq_render_done
);

    logic [9:0] osc_count;
    logic [3:0] rate_match;
    logic       tick;
    logic       active;
    logic       enabled;

    assign tick    = osc_count == 10'(`PRC_TICK_CLOCKS - 1);
    assign active  = regs.rate[7:4] == rate_match;
    assign enabled = regs.mode[1] | regs.mode[3];

    always_comb
    begin
        case (regs.rate[3:1])
            3'd0:    rate_match = 4'd2;  // Every 3rd frame
            3'd1:    rate_match = 4'd5;
            3'd2:    rate_match = 4'd8;
            3'd3:    rate_match = 4'd11;
            3'd4:    rate_match = 4'd1;  // Every 2nd frame
            3'd5:    rate_match = 4'd3;
            3'd6:    rate_match = 4'd5;
            default: rate_match = 4'd7;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            osc_count       <= 10'd0;
            counter         <= 7'd1;
            skip_clear      <= 1'b0;
            skip_increment  <= 1'b0;
            bus_request     <= 1'b0;
            render_start    <= 1'b0;
            irq_render_done <= 1'b0;
        end
        else
        begin
            skip_clear      <= 1'b0;
            skip_increment  <= 1'b0;
            render_start    <= 1'b0;
            irq_render_done <= 1'b0;
            osc_count       <= tick ? 10'd0 : osc_count + 10'd1;

            if (tick)
            begin
                counter <= (counter == `PRC_FRAME_TICKS) ? 7'd1 : counter + 7'd1;

                if (active && counter == `PRC_RENDER_TICK && enabled)
                begin
                    bus_request  <= 1'b1; // Open the render window
                    render_start <= 1'b1;
                end

                if (counter == `PRC_FRAME_TICKS)
                begin
                    if (active)
                    begin
                        bus_request     <= 1'b0;
                        irq_render_done <= 1'b1;
                        skip_clear      <= 1'b1;
                    end
                    else
                        skip_increment  <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== prc_map_renderer.sv ====
`default_nettype none

`include "prc_defs.svh"

module prc_map_renderer import prc_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        start,
    input  wire logic        bus_ack,
    input  wire logic [7:0]  bus_data_in,
    input  wire logic [23:0] map_base,
    output prc_bus_cmd_t     cmd,
    output logic             done
);

    logic       busy;
    logic [2:0] step;   // Even steps set up, odd steps strobe
    logic [6:0] column;
    logic [2:0] page;
    logic       last;

    assign last = column == 7'(`PRC_FB_COLUMNS - 1) && page == 3'(`PRC_FB_PAGES - 1);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            busy   <= 1'b0;
            step   <= 3'd0;
            column <= 7'd0;
            page   <= 3'd0;
            cmd    <= '0;
            done   <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy   <= 1'b1;
                step   <= 3'd0;
                column <= 7'd0;
                page   <= 3'd0;
            end
            else if (busy && bus_ack)
            begin
                step <= (step == 3'd5) ? 3'd0 : step + 3'd1;
                case (step)
                    3'd0:
                    begin
                        // Tile index from the map
                        cmd.address <= `PRC_TILEMAP_BASE
                                       + 24'(page) * 24'(`PRC_MAP_COLUMNS)
                                       + 24'(column[6:3]);
                        cmd.read    <= 1'b1;
                    end
                    3'd1:
                    begin
                        cmd.read <= 1'b0;
                        cmd.data <= bus_data_in;
                    end
                    3'd2:
                    begin
                        // Tile row byte, eight bytes per tile
                        cmd.address <= map_base + {13'd0, cmd.data, column[2:0]};
                        cmd.read    <= 1'b1;
                    end
                    3'd3:
                    begin
                        cmd.read <= 1'b0;
                        cmd.data <= bus_data_in;
                    end
                    3'd4:
                    begin
                        cmd.address <= `PRC_FB_BASE
                                       + 24'(page) * 24'(`PRC_FB_COLUMNS) + 24'(column);
                        cmd.write   <= 1'b1;
                    end
                    default:
                    begin
                        cmd.write <= 1'b0;
                        column    <= (column == 7'(`PRC_FB_COLUMNS - 1)) ? 7'd0
                                                                           : column + 7'd1;
                        if (column == 7'(`PRC_FB_COLUMNS - 1))
                            page <= page + 3'd1;
                        if (last)
                        begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== prc_frame_copier.sv ====
`default_nettype none

`include "prc_defs.svh"

module prc_frame_copier import prc_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       start,
    input  wire logic       bus_ack,
    input  wire logic [7:0] bus_data_in,
    output prc_bus_cmd_t    cmd,
    output logic            done
);

    typedef enum logic [2:0]
    {
        COPY_IDLE,
        COPY_COLUMN_LO,
        COPY_COLUMN_HI,
        COPY_PAGE_SET,
        COPY_FB_READ,
        COPY_LCD_WRITE
    } copy_state_e;

    copy_state_e state;
    logic        strobe_phase;
    logic [6:0]  column;
    logic [2:0]  page;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state        <= COPY_IDLE;
            strobe_phase <= 1'b0;
            column       <= 7'd0;
            page         <= 3'd0;
            cmd          <= '0;
            done         <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                state        <= COPY_COLUMN_LO;
                strobe_phase <= 1'b0;
                column       <= 7'd0;
                page         <= 3'd0;
            end
            else if (state != COPY_IDLE && bus_ack)
            begin
                strobe_phase <= !strobe_phase;
                if (!strobe_phase)
                begin
                    cmd.address <= `PRC_LCD_CMD;
                    cmd.write   <= 1'b1;
                    case (state)
                        COPY_COLUMN_LO: cmd.data <= 8'h10;
                        COPY_COLUMN_HI: cmd.data <= 8'h00;
                        COPY_PAGE_SET:  cmd.data <= {5'b10110, page};
                        COPY_FB_READ:
                        begin
                            cmd.address <= `PRC_FB_BASE
                                           + 24'(page) * 24'(`PRC_FB_COLUMNS) + 24'(column);
                            cmd.write   <= 1'b0;
                            cmd.read    <= 1'b1;
                        end
                        default:        cmd.address <= `PRC_LCD_DATA; // Byte already held
                    endcase
                end
                else
                begin
                    cmd.read  <= 1'b0;
                    cmd.write <= 1'b0;
                    case (state)
                        COPY_COLUMN_LO: state <= COPY_COLUMN_HI;
                        COPY_COLUMN_HI: state <= COPY_PAGE_SET;
                        COPY_PAGE_SET:  state <= COPY_FB_READ;
                        COPY_FB_READ:
                        begin
                            cmd.data <= bus_data_in;
                            state    <= COPY_LCD_WRITE;
                        end
                        default:
                        begin
                            column <= column + 7'd1;
                            state  <= COPY_FB_READ;
                            if (column == 7'(`PRC_FB_COLUMNS - 1))
                            begin
                                column <= 7'd0;
                                page   <= page + 3'd1;
                                state  <= COPY_COLUMN_LO; // Next page
                                if (page == 3'(`PRC_FB_PAGES - 1))
                                begin
                                    state <= COPY_IDLE;
                                    done  <= 1'b1;
                                end
                            end
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== prc_render_control.sv ====
`default_nettype none

module prc_render_control import prc_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  prc_regs_t       regs,
    input  wire logic       render_start,
    input  prc_bus_cmd_t    map_cmd,
    input  prc_bus_cmd_t    copy_cmd,
    input  wire logic       map_done,
    input  wire logic       copy_done,
    input  wire logic       bus_ack,
    input  wire logic [7:0] read_data,
    output logic            map_start,
    output logic            copy_start,
    output prc_bus_cmd_t    bus_cmd,
    output logic      [7:0] bus_data_out,
    output logic            irq_frame_copy
);

    prc_engine_e  engine;
    prc_bus_cmd_t active_cmd;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            engine         <= ENGINE_IDLE;
            map_start      <= 1'b0;
            copy_start     <= 1'b0;
            irq_frame_copy <= 1'b0;
        end
        else
        begin
            map_start      <= 1'b0;
            copy_start     <= 1'b0;
            irq_frame_copy <= 1'b0;
            case (engine)
                ENGINE_IDLE:
                begin
                    if (render_start && regs.mode[1])
                    begin
                        engine    <= ENGINE_MAP_DRAW;
                        map_start <= 1'b1;
                    end
                    else if (render_start && regs.mode[3])
                    begin
                        engine     <= ENGINE_FRAME_COPY;
                        copy_start <= 1'b1;
                    end
                end
                ENGINE_MAP_DRAW:
                begin
                    if (map_done)
                    begin
                        engine     <= regs.mode[3] ? ENGINE_FRAME_COPY : ENGINE_IDLE;
                        copy_start <= regs.mode[3];
                    end
                end
                ENGINE_FRAME_COPY:
                begin
                    if (copy_done)
                    begin
                        engine         <= ENGINE_IDLE;
                        irq_frame_copy <= 1'b1;
                    end
                end
                default: engine <= ENGINE_IDLE;
            endcase
        end
    end

    always_comb
    begin
        case (engine)
            ENGINE_MAP_DRAW:   active_cmd = map_cmd;
            ENGINE_FRAME_COPY: active_cmd = copy_cmd;
            default:           active_cmd = '0;
        endcase
        bus_cmd       = active_cmd;
        bus_cmd.read  = active_cmd.read & bus_ack;  // Strobes only in granted cycles
        bus_cmd.write = active_cmd.write & bus_ack;
    end

    assign bus_data_out = bus_ack ? bus_cmd.data : read_data;

endmodule

`default_nettype wire

// ==== prc_top.sv ====
`default_nettype none

module prc_top import prc_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        bus_write,
    input  wire logic        bus_read,
    input  wire logic [23:0] bus_address_in,
    input  wire logic [7:0]  bus_data_in,
    input  wire logic        bus_ack,
    output logic      [7:0]  bus_data_out,
    output logic      [23:0] bus_address_out,
    output logic             write,
    output logic             read,
    output logic             bus_request,
    output logic             irq_frame_copy,
    output logic             irq_render_done
);

    prc_regs_t    regs;
    prc_bus_cmd_t map_cmd;
    prc_bus_cmd_t copy_cmd;
    prc_bus_cmd_t bus_cmd;
    logic [7:0]   read_data;
    logic [6:0]   counter;
    logic         skip_clear;
    logic         skip_increment;
    logic         render_start;
    logic         map_start;
    logic         map_done;
    logic         copy_start;
    logic         copy_done;

    prc_registers prc_registers_inst
    (
        .clk, .reset, .bus_write, .bus_address_in, .bus_data_in,
        .skip_clear, .skip_increment, .counter, .regs, .read_data,
        .divider_changed()
    );

    prc_frame_timer prc_frame_timer_inst
    (
        .clk, .reset, .regs, .counter, .skip_clear, .skip_increment,
        .bus_request, .render_start, .irq_render_done
    );

    prc_map_renderer prc_map_renderer_inst
    (
        .clk, .reset, .start(map_start), .bus_ack, .bus_data_in,
        .map_base(regs.map_base), .cmd(map_cmd), .done(map_done)
    );

    prc_frame_copier prc_frame_copier_inst
    (
        .clk, .reset, .start(copy_start), .bus_ack, .bus_data_in,
        .cmd(copy_cmd), .done(copy_done)
    );

    prc_render_control prc_render_control_inst
    (
        .clk, .reset, .regs, .render_start, .map_cmd, .copy_cmd,
        .map_done, .copy_done, .bus_ack, .read_data, .map_start,
        .copy_start, .bus_cmd, .bus_data_out, .irq_frame_copy
    );

    assign bus_address_out = bus_cmd.address;
    assign write           = bus_cmd.write;
    assign read            = bus_cmd.read;

endmodule

`default_nettype wire

// ==== prc_assertions.sv ====
`default_nettype none

module prc_assertions
(
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       read,
    input wire logic       write,
    input wire logic       bus_ack,
    input wire logic       bus_request,
    input wire logic       irq_frame_copy,
    input wire logic       irq_render_done,
    input wire logic [5:0] mode
);

    timeunit 1ns;
    timeprecision 100ps;

    strobe_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write strobes high together");

    // Every strobe is granted and the next access needs its own setup cycle
    strobe_granted: assert property (@(posedge clk) disable iff (reset)
                                     (read || write) |-> bus_ack ##1 !(read || write))
        else $error("bus strobe without bus_ack or without a setup cycle");

    // Interrupts last exactly one cycle
    copy_irq_pulse: assert property (@(posedge clk) disable iff (reset)
                                     irq_frame_copy |=> !irq_frame_copy)
        else $error("irq_frame_copy longer than one cycle");

    done_irq_pulse: assert property (@(posedge clk) disable iff (reset)
                                     irq_render_done |=> !irq_render_done)
        else $error("irq_render_done longer than one cycle");

    request_gated: assert property (@(posedge clk) disable iff (reset)
                                    !(mode[1] || mode[3]) |-> !bus_request)
        else $error("bus_request with map draw and frame copy disabled");

endmodule

bind prc_top prc_assertions prc_assertions_inst
(
    .clk, .reset, .read, .write, .bus_ack, .bus_request,
    .irq_frame_copy, .irq_render_done, .mode(regs.mode)
);

`default_nettype wire

// ==== prc_tb.sv ====
`default_nettype none

`include "prc_defs.svh"

module prc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CLOCKS    = `PRC_TICK_CLOCKS * `PRC_FRAME_TICKS;
    localparam int FASTEST_FRAMES  = 2;  // Divider setting 4 renders every 2nd frame
    localparam int WATCHDOG_CLOCKS = 6 * FASTEST_FRAMES * FRAME_CLOCKS; // Six rendered frames
    localparam int FB_BYTES        = `PRC_FB_COLUMNS * `PRC_FB_PAGES;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        bus_write = 1'b0;
    logic        bus_read = 1'b0;
    logic        bus_ack = 1'b0;
    logic [23:0] bus_address_in = 24'd0;
    logic [7:0]  cpu_data = 8'd0;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic [23:0] bus_address_out;
    logic        write;
    logic        read;
    logic        bus_request;
    logic        irq_frame_copy;
    logic        irq_render_done;

    logic [7:0]  mem [0:65535];
    logic [7:0]  lcd_q [$];
    logic [7:0]  fb_model [0:FB_BYTES-1];
    logic [7:0]  reg_model [0:10];
    longint      cycle = 0;
    longint      done_cycle = 0;
    longint      last_copy_cycle = 0;
    int          done_count = 0;
    int          copy_pulses = 0;
    int          gating_hits = 0;
    int          error_count = 0;
    logic        gaps_on = 1'b0;
    logic        gating_watch = 1'b0;

    prc_top prc_top_inst
    (
        .clk, .reset, .bus_write, .bus_read, .bus_address_in, .bus_data_in,
        .bus_ack, .bus_data_out, .bus_address_out, .write, .read,
        .bus_request, .irq_frame_copy, .irq_render_done
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // Memory answers engine read strobes, the CPU drives the data pins otherwise
    assign bus_data_in = read ? mem[bus_address_out[15:0]] : cpu_data;

    // Grant follows the request, with random gaps when enabled
    always @(posedge clk)
    begin
        #1;
        bus_ack = bus_request && !(gaps_on && $urandom_range(7) == 0);
    end

    always @(negedge clk)
    begin
        if (!reset && write)
        begin
            if (bus_address_out == `PRC_LCD_CMD || bus_address_out == `PRC_LCD_DATA)
                lcd_q.push_back(bus_data_out);
            else
                mem[bus_address_out[15:0]] = bus_data_out;
        end
        if (irq_frame_copy)
        begin
            copy_pulses++;
            last_copy_cycle = cycle;
        end
        if (irq_render_done)
        begin
            done_count++;
            done_cycle = cycle;
        end
        if (gating_watch && bus_request)
            gating_hits++;
    end

    initial
    begin
        repeat (WATCHDOG_CLOCKS) @(posedge clk);
        $display("Timeout: no result after %0d clocks, the render engines stalled", WATCHDOG_CLOCKS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
        assert (got == exp)
        else
        begin
            error_count++;
            $display("error at %0t: %s read %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic cpu_write(input logic [23:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        bus_address_in = addr;
        cpu_data       = data;
        bus_write      = 1'b1;
        @(posedge clk);
        #1;
        bus_write = 1'b0;
    endtask

    task automatic cpu_read(input logic [23:0] addr, output logic [7:0] data);
        @(posedge clk);
        #1;
        bus_address_in = addr;
        bus_read       = 1'b1;
        @(negedge clk);
        data = bus_data_out;    // Combinational read-back
        @(posedge clk);
        #1;
        bus_read = 1'b0;
    endtask

    // Register model follows the write masks of each address
    task automatic model_write(input logic [23:0] addr, input logic [7:0] d);
        case (addr)
            `PRC_REG_MODE:     reg_model[0] = {2'd0, d[5:0]};
            `PRC_REG_RATE:
            begin
                if (d[3:1] != reg_model[1][3:1])
                    reg_model[1][7:4] = 4'd0;
                reg_model[1][3:0] = d[3:0];
            end
            `PRC_REG_MAP_LO:   reg_model[2] = d & 8'hF8;
            `PRC_REG_MAP_MID:  reg_model[3] = d;
            `PRC_REG_MAP_HI:   reg_model[4] = d & 8'h1F;
            `PRC_REG_SCROLL_Y: reg_model[5] = d & 8'h7F;
            `PRC_REG_SCROLL_X: reg_model[6] = d & 8'h7F;
            default:
            begin
            end
        endcase
    endtask

    function automatic int frames_per_render(input logic [2:0] setting);
        case (setting)
            3'd0:    return 3;
            3'd1:    return 6;
            3'd2:    return 9;
            3'd3:    return 12;
            3'd4:    return 2;
            3'd5:    return 4;
            3'd6:    return 6;
            default: return 8;
        endcase
    endfunction

    task automatic build_fb_model(input logic [15:0] base);
        logic [7:0] tile;
        for (int p = 0; p < `PRC_FB_PAGES; p++)
        begin
            for (int c = 0; c < `PRC_FB_COLUMNS; c++)
            begin
                tile = mem[16'(32'h1360 + p * `PRC_MAP_COLUMNS + c / 8)];
                fb_model[p * `PRC_FB_COLUMNS + c] = mem[16'(base + tile * 8 + c % 8)];
            end
        end
    endtask

    task automatic check_framebuffer();
        for (int i = 0; i < FB_BYTES; i++)
            check_value($sformatf("framebuffer byte %0d", i), mem[16'(32'h1000 + i)], fb_model[i]);
    endtask

    task automatic check_lcd_stream();
        int k;
        assert (lcd_q.size() == `PRC_FB_PAGES * (`PRC_FB_COLUMNS + 3))
        else
        begin
            error_count++;
            $display("error at %0t: LCD received %0d bytes", $time, lcd_q.size());
        end
        if (lcd_q.size() == `PRC_FB_PAGES * (`PRC_FB_COLUMNS + 3))
        begin
            k = 0;
            for (int p = 0; p < `PRC_FB_PAGES; p++)
            begin
                check_value("LCD column low", lcd_q[k], 8'h10);
                check_value("LCD column high", lcd_q[k+1], 8'h00);
                check_value("LCD page set", lcd_q[k+2], 8'hB0 + 8'(p));
                k += 3;
                for (int c = 0; c < `PRC_FB_COLUMNS; c++)
                begin
                    check_value($sformatf("LCD page %0d column %0d", p, c), lcd_q[k],
                                fb_model[p * `PRC_FB_COLUMNS + c]);
                    k++;
                end
            end
        end
    endtask

    // One rendered frame with copy, checked for order and frame spacing
    task automatic run_copy_frame(input longint period);
        int     copies_before;
        longint prev_done;
        copies_before = copy_pulses;
        prev_done     = done_cycle;
        lcd_q.delete();
        wait (done_count != 0 && done_cycle != prev_done);
        @(posedge clk);
        #1;
        assert (copy_pulses - copies_before == 1 && last_copy_cycle < done_cycle)
        else
        begin
            error_count++;
            $display("error at %0t: %0d copy interrupts before render done", $time,
                     copy_pulses - copies_before);
        end
        assert (done_cycle - prev_done == period)
        else
        begin
            error_count++;
            $display("error at %0t: render done spacing %0d clocks", $time,
                     done_cycle - prev_done);
        end
        check_framebuffer();
        check_lcd_stream();
    endtask

    initial
    begin
        logic [7:0]  d;
        logic [23:0] addr;
        logic [15:0] map_base;
        longint      period;
        longint      prev_done;

        void'($urandom(32'h5ac));
        for (int i = 0; i < 65536; i++)
            mem[i] = (i >= 32'h1000 && i < 32'h1000 + FB_BYTES) ? 8'd0 : 8'($urandom);
        for (int i = 0; i < 11; i++)
            reg_model[i] = 8'd0;
        reg_model[10] = 8'd1;   // Tick counter starts at 1

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        assert (!read && !write && !bus_request && !irq_frame_copy && !irq_render_done)
        else
        begin
            error_count++;
            $display("Outputs not low after reset");
        end
        for (int a = 0; a < 11; a++)
        begin
            cpu_read(`PRC_REG_MODE + 24'(a), d);
            check_value($sformatf("reset value of %h", `PRC_REG_MODE + 24'(a)), d, reg_model[a]);
        end

        // Random register traffic, sprite bases included
        for (int n = 0; n < 40; n++)
        begin
            addr = `PRC_REG_MODE + 24'($urandom_range(9));
            d    = 8'($urandom);
            cpu_write(addr, d);
            model_write(addr, d);
            cpu_read(addr, d);
            check_value($sformatf("register %h", addr), d, reg_model[addr - `PRC_REG_MODE]);
        end

        // Mode 0 with divider setting 4 must never request the bus
        cpu_write(`PRC_REG_MODE, 8'h00);
        cpu_write(`PRC_REG_RATE, 8'h08);
        gating_watch = 1'b1;
        repeat (2 * FRAME_CLOCKS) @(posedge clk);
        gating_watch = 1'b0;
        assert (gating_hits == 0)
        else
        begin
            error_count++;
            $display("Bus was requested with rendering disabled");
        end

        // Map draw only
        map_base = {8'h40 + 8'($urandom_range(8'h9F)), 8'($urandom) & 8'hF8};
        cpu_write(`PRC_REG_MAP_LO, map_base[7:0]);
        cpu_write(`PRC_REG_MAP_MID, map_base[15:8]);
        cpu_write(`PRC_REG_MAP_HI, 8'h00);
        build_fb_model(map_base);
        cpu_write(`PRC_REG_MODE, 8'h02);
        lcd_q.delete();
        prev_done = done_cycle;
        wait (done_cycle != prev_done);
        @(posedge clk);
        #1;
        check_framebuffer();
        assert (lcd_q.size() == 0)
        else
        begin
            error_count++;
            $display("LCD was written during map draw only");
        end

        period = longint'(frames_per_render(3'd4)) * FRAME_CLOCKS;
        cpu_write(`PRC_REG_MODE, 8'h0A);
        run_copy_frame(period);

        // Same frame with random grant gaps, framebuffer wiped first
        gaps_on = 1'b1;
        for (int i = 0; i < FB_BYTES; i++)
            mem[16'(32'h1000 + i)] = 8'd0;
        run_copy_frame(period);

        $display("Checks failed: %0d", error_count);
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
prc_pkg.sv
prc_registers.sv
prc_frame_timer.sv
prc_map_renderer.sv
prc_frame_copier.sv
prc_render_control.sv
prc_top.sv
prc_assertions.sv
prc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PRC testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module prc_tb -o prc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/prc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation log has no result line"
    exit 1
fi
exit 0
